// File: rtl/msx_bus_pkg.sv
package msx_bus_pkg;

    // One CPU bus cycle as seen at one rising clock edge
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        iorq;
        logic        mreq;
        logic        rd;
        logic        wr;
    } cpu_bus_t;

    // Read data returned by a device on the I/O bus
    typedef logic [7:0] io_data_t;

    // Signed audio sample
    typedef logic signed [15:0] sound_t;

    // A device not selected for a read drives all ones
    localparam io_data_t io_idle = 8'hFF;

    // Sound output value with no channel active
    localparam sound_t sound_silent = '0;

endpackage

// File: rtl/msx_dev_pkg.sv
package msx_dev_pkg;

    // Devices on the hub, index into the I/O map table
    typedef enum logic [1:0] {
        DEV_LATCH_PORT = 2'd0,
        DEV_PSG        = 2'd1,
        DEV_PPI        = 2'd2,
        DEV_TIMER      = 2'd3
    } dev_id_e;

    localparam int DEV_COUNT = 4;

    // Port window of one device
    typedef struct packed {
        logic       enable;
        logic [7:0] base;
        logic [7:0] mask;
    } io_device_t;

    // Map loaded at reset, in dev_id_e order
    localparam io_device_t io_map_default [DEV_COUNT] = '{
        '{enable: 1'b1, base: 8'hFC, mask: 8'hFC},
        '{enable: 1'b1, base: 8'hA0, mask: 8'hFC},
        '{enable: 1'b1, base: 8'hA8, mask: 8'hFC},
        '{enable: 1'b1, base: 8'hE0, mask: 8'hFE}
    };

    // True when an I/O cycle falls inside the device window
    function automatic logic io_hit(io_device_t dev, logic iorq, logic [7:0] port);
        return iorq && dev.enable && ((port & dev.mask) == dev.base);
    endfunction

endpackage

// File: rtl/dev_io_map.sv
module dev_io_map
    import msx_dev_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cfg_we,
    input  dev_id_e    cfg_dev,
    input  io_device_t cfg_entry,
    output io_device_t io_device [DEV_COUNT]
);

    // Window table, one entry per device
    io_device_t map_q [DEV_COUNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEV_COUNT; i++) begin
                map_q[i] <= io_map_default[i];
            end
        end else if (cfg_we) begin
            // New window is seen by the decoders from the next cycle on
            map_q[cfg_dev] <= cfg_entry;
        end
    end

    // Every device decodes against its own entry
    always_comb begin
        for (int i = 0; i < DEV_COUNT; i++) begin
            io_device[i] = map_q[i];
        end
    end

endmodule

// File: rtl/dev_latch_port.sv
module dev_latch_port
    import msx_bus_pkg::*;
    import msx_dev_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  cpu_bus_t   cpu_bus,
    input  io_device_t io_device,
    output io_data_t   data,
    output logic [7:0] data_to_mapper
);

    // Segment register per 16 KB page
    logic [7:0] seg_q [4];
    logic       sel;
    logic [1:0] port_idx;
    logic [1:0] page;

    assign sel      = io_hit(io_device, cpu_bus.iorq, cpu_bus.addr[7:0]);
    assign port_idx = cpu_bus.addr[1:0];
    assign page     = cpu_bus.addr[15:14];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Pages 0 to 3 start on segments 3 down to 0
            seg_q[0] <= 8'd3;
            seg_q[1] <= 8'd2;
            seg_q[2] <= 8'd1;
            seg_q[3] <= 8'd0;
        end else if (sel && cpu_bus.wr) begin
            seg_q[port_idx] <= cpu_bus.wdata;
        end
    end

    // Read-back of the addressed segment register
    assign data = (sel && cpu_bus.rd) ? seg_q[port_idx] : io_idle;

    // Segment for the page the CPU is addressing
    assign data_to_mapper = seg_q[page];

endmodule

// File: rtl/dev_psg_tone.sv
module dev_psg_tone
    import msx_bus_pkg::*;
    import msx_dev_pkg::*;
#(
    parameter int TONE_PRESCALE = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  cpu_bus_t   cpu_bus,
    input  io_device_t io_device,
    output io_data_t   data,
    output sound_t     sound
);

    localparam int PW = (TONE_PRESCALE > 1) ? $clog2(TONE_PRESCALE) : 1;

    logic          sel;
    logic [3:0]    idx_q;
    logic          idx_valid;
    logic [7:0]    reg_q [6];
    logic [PW-1:0] pre_q;
    logic          tick;
    sound_t        level [2];
    sound_t        sound_q;

    assign sel       = io_hit(io_device, cpu_bus.iorq, cpu_bus.addr[7:0]);
    assign idx_valid = (idx_q < 4'd6);

    // Index latch at base+0, register data at base+1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_q <= '0;
            for (int i = 0; i < 6; i++) begin
                reg_q[i] <= '0;
            end
        end else if (sel && cpu_bus.wr) begin
            if (cpu_bus.addr[1:0] == 2'd0) begin
                idx_q <= cpu_bus.wdata[3:0];
            end else if (cpu_bus.addr[1:0] == 2'd1 && idx_valid) begin
                reg_q[idx_q[2:0]] <= cpu_bus.wdata;
            end
        end
    end

    // Register read-back at base+2
    assign data = (sel && cpu_bus.rd && cpu_bus.addr[1:0] == 2'd2 && idx_valid)
                  ? reg_q[idx_q[2:0]] : io_idle;

    // Shared prescaler for both tone channels
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_q <= '0;
        end else if (tick) begin
            pre_q <= '0;
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    assign tick = (pre_q == PW'(TONE_PRESCALE - 1));

    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        logic [11:0] period;
        logic [3:0]  volume;
        logic [11:0] cnt_q;
        logic        phase_q;
        sound_t      amp;

        assign period = {reg_q[3*ch+1][3:0], reg_q[3*ch]};
        assign volume = reg_q[3*ch+2][3:0];
        assign amp    = $signed({4'b0000, volume, 8'h00});

        // Phase flips after period+1 prescaler ticks
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                cnt_q   <= '0;
                phase_q <= 1'b0;
            end else if (tick) begin
                if (cnt_q >= period) begin
                    cnt_q   <= '0;
                    phase_q <= ~phase_q;
                end else begin
                    cnt_q <= cnt_q + 12'd1;
                end
            end
        end

        assign level[ch] = phase_q ? amp : -amp;
    end

    // Mixer output, one cycle behind the phases
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sound_q <= sound_silent;
        end else begin
            sound_q <= level[0] + level[1];
        end
    end

    assign sound = sound_q;

endmodule

// File: rtl/dev_frame_timer.sv
module dev_frame_timer
    import msx_bus_pkg::*;
    import msx_dev_pkg::*;
#(
    parameter int FRAME_TICKS = 300
) (
    input  logic       clk,
    input  logic       arst_n,
    input  cpu_bus_t   cpu_bus,
    input  io_device_t io_device,
    output io_data_t   data,
    output logic       irq
);

    localparam int CW = (FRAME_TICKS > 1) ? $clog2(FRAME_TICKS) : 1;

    logic [CW-1:0] cnt_q;
    logic          wrap;
    logic          sel;
    logic          stat_rd;
    logic          pending_q;

    assign wrap    = (cnt_q == CW'(FRAME_TICKS - 1));
    assign sel     = io_hit(io_device, cpu_bus.iorq, cpu_bus.addr[7:0]);
    // Status port sits at the even address of the window
    assign stat_rd = sel && cpu_bus.rd && !cpu_bus.addr[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q     <= '0;
            pending_q <= 1'b0;
        end else begin
            cnt_q <= wrap ? '0 : cnt_q + 1'b1;
            // Frame end beats an acknowledge at the same edge
            if (wrap) begin
                pending_q <= 1'b1;
            end else if (stat_rd) begin
                pending_q <= 1'b0;
            end
        end
    end

    assign data = stat_rd ? {pending_q, 7'h7F} : io_idle;
    assign irq  = pending_q;

endmodule

// File: rtl/dev_ppi.sv
module dev_ppi
    import msx_bus_pkg::*;
    import msx_dev_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  cpu_bus_t   cpu_bus,
    input  io_device_t io_device,
    output io_data_t   data,
    output logic [7:0] slot_config,
    output logic       keybeep,
    output logic       tape_motor_on
);

    logic       sel;
    logic       slot_acc;
    logic       bsr_wr;
    logic [7:0] slot_q;
    logic       motor_q;
    logic       beep_q;

    assign sel      = io_hit(io_device, cpu_bus.iorq, cpu_bus.addr[7:0]);
    assign slot_acc = sel && cpu_bus.addr[1:0] == 2'd1;
    // Bit set/reset form of the control port, mode writes are ignored
    assign bsr_wr   = sel && cpu_bus.wr && cpu_bus.addr[1:0] == 2'd3 && !cpu_bus.wdata[7];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_q  <= '0;
            motor_q <= 1'b0;
            beep_q  <= 1'b0;
        end else begin
            if (slot_acc && cpu_bus.wr) begin
                slot_q <= cpu_bus.wdata;
            end
            if (bsr_wr && cpu_bus.wdata[3:1] == 3'd6) begin
                motor_q <= cpu_bus.wdata[0];
            end
            if (bsr_wr && cpu_bus.wdata[3:1] == 3'd7) begin
                beep_q <= cpu_bus.wdata[0];
            end
        end
    end

    assign data          = (slot_acc && cpu_bus.rd) ? slot_q : io_idle;
    assign slot_config   = slot_q;
    assign tape_motor_on = motor_q;
    assign keybeep       = beep_q;

endmodule

// File: rtl/msx_devices.sv
module msx_devices
    import msx_bus_pkg::*;
    import msx_dev_pkg::*;
#(
    parameter int FRAME_TICKS   = 300,
    parameter int TONE_PRESCALE = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  cpu_bus_t   cpu_bus,
    input  logic       cfg_we,
    input  dev_id_e    cfg_dev,
    input  io_device_t cfg_entry,
    output io_data_t   data,
    output logic [7:0] data_to_mapper,
    output sound_t     sound,
    output logic       cpu_interrupt,
    output logic [7:0] slot_config,
    output logic       keybeep,
    output logic       tape_motor_on
);

    io_device_t io_device [DEV_COUNT];

    io_data_t   latch_port_data;
    logic [7:0] latch_port_data_to_mapper;
    io_data_t   psg_data;
    sound_t     psg_sound;
    io_data_t   ppi_data;
    io_data_t   timer_data;
    logic       timer_irq;

    // Idle devices drive FF so the read bus is a wired AND
    assign data           = latch_port_data & psg_data & ppi_data & timer_data;
    assign data_to_mapper = latch_port_data_to_mapper;
    assign sound          = psg_sound;
    assign cpu_interrupt  = timer_irq;

    dev_io_map io_map (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_dev   (cfg_dev),
        .cfg_entry (cfg_entry),
        .io_device (io_device)
    );

    dev_latch_port latch_port (
        .clk            (clk),
        .arst_n         (arst_n),
        .cpu_bus        (cpu_bus),
        .io_device      (io_device[DEV_LATCH_PORT]),
        .data           (latch_port_data),
        .data_to_mapper (latch_port_data_to_mapper)
    );

    dev_psg_tone #(.TONE_PRESCALE(TONE_PRESCALE)) psg (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_bus   (cpu_bus),
        .io_device (io_device[DEV_PSG]),
        .data      (psg_data),
        .sound     (psg_sound)
    );

    dev_ppi ppi (
        .clk           (clk),
        .arst_n        (arst_n),
        .cpu_bus       (cpu_bus),
        .io_device     (io_device[DEV_PPI]),
        .data          (ppi_data),
        .slot_config   (slot_config),
        .keybeep       (keybeep),
        .tape_motor_on (tape_motor_on)
    );

    dev_frame_timer #(.FRAME_TICKS(FRAME_TICKS)) frame_timer (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_bus   (cpu_bus),
        .io_device (io_device[DEV_TIMER]),
        .data      (timer_data),
        .irq       (timer_irq)
    );

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset goes away on a falling edge, clear of the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: tests/tb_msx_devices.sv
module tb_msx_devices
    import msx_bus_pkg::*;
    import msx_dev_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_TICKS    = 300;
    localparam int TONE_PRESCALE  = 4;
    localparam int PLANNED_CYCLES = 1250;
    localparam int CYCLE_LIMIT    = 4 * PLANNED_CYCLES;

    logic       clk;
    logic       arst_n;
    cpu_bus_t   cpu_bus;
    logic       cfg_we;
    dev_id_e    cfg_dev;
    io_device_t cfg_entry;
    io_data_t   data;
    logic [7:0] data_to_mapper;
    sound_t     sound;
    logic       cpu_interrupt;
    logic [7:0] slot_config;
    logic       keybeep;
    logic       tape_motor_on;

    // Reference model state
    io_device_t map_m [DEV_COUNT];
    logic [7:0] seg_m [4];
    logic [3:0] idx_m;
    logic [7:0] psg_m [6];
    int         pre_m;
    int         tone_cnt_m [2];
    logic       phase_m [2];
    sound_t     sound_m;
    logic [7:0] slot_m;
    logic       motor_m;
    logic       beep_m;
    int         tcnt_m;
    logic       pend_m;

    logic [31:0] lfsr_q = 32'h7107fc70;
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;

    tb_clock #(.HALF_PERIOD(10), .RESET_CYCLES(16)) clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    msx_devices #(.FRAME_TICKS(FRAME_TICKS), .TONE_PRESCALE(TONE_PRESCALE)) msx_devices_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .cpu_bus        (cpu_bus),
        .cfg_we         (cfg_we),
        .cfg_dev        (cfg_dev),
        .cfg_entry      (cfg_entry),
        .data           (data),
        .data_to_mapper (data_to_mapper),
        .sound          (sound),
        .cpu_interrupt  (cpu_interrupt),
        .slot_config    (slot_config),
        .keybeep        (keybeep),
        .tape_motor_on  (tape_motor_on)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic cpu_bus_t make_bus(input logic [15:0] addr, input logic [7:0] wd,
                                          input logic rd, input logic wr);
        cpu_bus_t b;
        b = '0;
        b.addr  = addr;
        b.wdata = wd;
        b.iorq  = rd | wr;
        b.rd    = rd;
        b.wr    = wr;
        return b;
    endfunction

    function automatic logic port_selected(input io_device_t d, input cpu_bus_t b);
        return b.iorq && d.enable && ((b.addr[7:0] & d.mask) == d.base);
    endfunction

    // Wired AND of what every device returns for this cycle
    function automatic io_data_t expect_read(input cpu_bus_t b);
        io_data_t r;
        r = 8'hFF;
        if (b.rd) begin
            if (port_selected(map_m[DEV_LATCH_PORT], b))
                r = r & seg_m[b.addr[1:0]];
            if (port_selected(map_m[DEV_PSG], b) && b.addr[1:0] == 2'd2 && idx_m < 4'd6)
                r = r & psg_m[idx_m[2:0]];
            if (port_selected(map_m[DEV_PPI], b) && b.addr[1:0] == 2'd1)
                r = r & slot_m;
            if (port_selected(map_m[DEV_TIMER], b) && !b.addr[0])
                r = r & {pend_m, 7'h7F};
        end
        return r;
    endfunction

    task automatic model_reset();
        map_m[DEV_LATCH_PORT] = {1'b1, 8'hFC, 8'hFC};
        map_m[DEV_PSG]        = {1'b1, 8'hA0, 8'hFC};
        map_m[DEV_PPI]        = {1'b1, 8'hA8, 8'hFC};
        map_m[DEV_TIMER]      = {1'b1, 8'hE0, 8'hFE};
        for (int i = 0; i < 4; i++) begin
            seg_m[i] = 8'(3 - i);
        end
        for (int i = 0; i < 6; i++) begin
            psg_m[i] = 8'h00;
        end
        for (int ch = 0; ch < 2; ch++) begin
            tone_cnt_m[ch] = 0;
            phase_m[ch]    = 1'b0;
        end
        idx_m   = 4'd0;
        pre_m   = 0;
        sound_m = 16'sd0;
        slot_m  = 8'h00;
        motor_m = 1'b0;
        beep_m  = 1'b0;
        tcnt_m  = 0;
        pend_m  = 1'b0;
    endtask

    task automatic model_step();
        cpu_bus_t    b;
        sound_t      lvl [2];
        logic [11:0] period;
        logic        tick;
        b = cpu_bus;
        // Frame end wins over a status read at the same edge
        if (tcnt_m == FRAME_TICKS - 1) begin
            tcnt_m = 0;
            pend_m = 1'b1;
        end else begin
            tcnt_m++;
            if (port_selected(map_m[DEV_TIMER], b) && b.rd && !b.addr[0])
                pend_m = 1'b0;
        end
        // Output sample reflects the phases before this edge
        for (int ch = 0; ch < 2; ch++) begin
            lvl[ch] = sound_t'(int'(psg_m[3*ch+2][3:0]) * 256);
            if (!phase_m[ch])
                lvl[ch] = -lvl[ch];
        end
        sound_m = lvl[0] + lvl[1];
        tick  = (pre_m == TONE_PRESCALE - 1);
        pre_m = tick ? 0 : pre_m + 1;
        for (int ch = 0; ch < 2; ch++) begin
            period = {psg_m[3*ch+1][3:0], psg_m[3*ch]};
            if (tick && tone_cnt_m[ch] >= int'(period)) begin
                tone_cnt_m[ch] = 0;
                phase_m[ch]    = ~phase_m[ch];
            end else if (tick) begin
                tone_cnt_m[ch]++;
            end
        end
        if (b.wr) begin
            if (port_selected(map_m[DEV_LATCH_PORT], b))
                seg_m[b.addr[1:0]] = b.wdata;
            if (port_selected(map_m[DEV_PSG], b) && b.addr[1:0] == 2'd0)
                idx_m = b.wdata[3:0];
            else if (port_selected(map_m[DEV_PSG], b) && b.addr[1:0] == 2'd1 && idx_m < 4'd6)
                psg_m[idx_m[2:0]] = b.wdata;
            if (port_selected(map_m[DEV_PPI], b) && b.addr[1:0] == 2'd1)
                slot_m = b.wdata;
            if (port_selected(map_m[DEV_PPI], b) && b.addr[1:0] == 2'd3 && !b.wdata[7]) begin
                if (b.wdata[3:1] == 3'd6)
                    motor_m = b.wdata[0];
                if (b.wdata[3:1] == 3'd7)
                    beep_m = b.wdata[0];
            end
        end
        if (cfg_we)
            map_m[cfg_dev] = cfg_entry;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            model_reset();
        else
            model_step();
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compare_data(input io_data_t got, input io_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic compare_mapper(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: data_to_mapper got %02h expected %02h", $time, got, exp);
        end
    endtask

    task automatic compare_sound(input sound_t got, input sound_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: sound got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic compare_irq(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: cpu_interrupt got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic compare_ctrl(input logic [7:0] slot_got, input logic [7:0] slot_exp,
                                input logic beep_got, input logic beep_exp,
                                input logic motor_got, input logic motor_exp);
        checks++;
        if (slot_got !== slot_exp || beep_got !== beep_exp || motor_got !== motor_exp) begin
            errors++;
            $display("[ERROR] %0t: slot/beep/motor got %02h/%b/%b expected %02h/%b/%b",
                     $time, slot_got, beep_got, motor_got, slot_exp, beep_exp, motor_exp);
        end
    endtask

    // Registered outputs are checked before new inputs go out
    task automatic drive_cycle(input cpu_bus_t b, input logic we, input dev_id_e dev,
                               input io_device_t entry);
        @(negedge clk);
        compare_mapper(data_to_mapper, seg_m[cpu_bus.addr[15:14]]);
        compare_sound(sound, sound_m);
        compare_irq(cpu_interrupt, pend_m);
        compare_ctrl(slot_config, slot_m, keybeep, beep_m, tape_motor_on, motor_m);
        cpu_bus   = b;
        cfg_we    = we;
        cfg_dev   = dev;
        cfg_entry = entry;
        #2;
        compare_data(data, expect_read(b), "read data");
    endtask

    task automatic bus_step(input cpu_bus_t b);
        drive_cycle(b, 1'b0, DEV_LATCH_PORT, '0);
    endtask

    task automatic idle_cycle();
        bus_step(make_bus(cpu_bus.addr, 8'h00, 1'b0, 1'b0));
    endtask

    task automatic io_op(input logic [7:0] port, input logic [7:0] hi, input logic [7:0] wd,
                         input logic rd, input logic wr);
        bus_step(make_bus({hi, port}, wd, rd, wr));
        idle_cycle();
    endtask

    task automatic read_check(input logic [7:0] port, input io_data_t exp, input string what);
        bus_step(make_bus({8'h00, port}, 8'h00, 1'b1, 1'b0));
        compare_data(data, exp, what);
        idle_cycle();
    endtask

    task automatic psg_write(input logic [3:0] r, input logic [7:0] v);
        io_op(8'hA0, 8'h00, {4'b0000, r}, 1'b0, 1'b1);
        io_op(8'hA1, 8'h00, v, 1'b0, 1'b1);
    endtask

    task automatic set_map(input dev_id_e dev, input io_device_t entry);
        drive_cycle(make_bus(cpu_bus.addr, 8'h00, 1'b0, 1'b0), 1'b1, dev, entry);
        idle_cycle();
    endtask

    initial begin
        logic [1:0] kind;
        logic [1:0] off;
        logic       rd_sel;
        logic [7:0] wd;
        logic [7:0] hi;
        logic [7:0] port;
        int         waited;
        cpu_bus   = '0;
        cfg_we    = 1'b0;
        cfg_dev   = DEV_LATCH_PORT;
        cfg_entry = '0;
        wait (arst_n === 1'b1);

        // Reset state and default mapper pages
        @(negedge clk);
        compare_irq(cpu_interrupt, 1'b0);
        compare_sound(sound, 16'sd0);
        compare_ctrl(slot_config, 8'h00, keybeep, 1'b0, tape_motor_on, 1'b0);
        for (int p = 0; p < 4; p++) begin
            bus_step(make_bus({2'(p), 6'b0, 6'b111111, 2'(p)}, 8'h00, 1'b1, 1'b0));
            compare_data(data, 8'(3 - p), "mapper page read-back");
            compare_mapper(data_to_mapper, 8'(3 - p));
            idle_cycle();
        end
        read_check(8'h10, 8'hFF, "unmapped port");

        // Random traffic over the latch, PSG and PPI windows
        for (int i = 0; i < 200; i++) begin
            kind   = 2'(take_bits(2));
            off    = 2'(take_bits(2));
            rd_sel = 1'(take_bits(1));
            wd     = 8'(take_bits(8));
            hi     = 8'(take_bits(8));
            case (kind)
                2'd0:    port = {6'b111111, off};
                2'd1:    port = {6'b101000, off};
                2'd2:    port = {6'b101010, off};
                default: port = 8'(take_bits(8));
            endcase
            io_op(port, hi, wd, rd_sel, !rd_sel);
        end

        // Bit set/reset on beeper and motor
        for (int i = 0; i < 8; i++) begin
            wd = {4'b0000, 2'b11, 1'(take_bits(1)), 1'(take_bits(1))};
            io_op(8'hAB, 8'h00, wd, 1'b0, 1'b1);
        end
        io_op(8'hAB, 8'h00, 8'h0F, 1'b0, 1'b1);
        io_op(8'hAB, 8'h00, 8'h0C, 1'b0, 1'b1);
        compare_ctrl(slot_config, slot_m, keybeep, 1'b1, tape_motor_on, 1'b0);

        // Tone channels with random periods and volumes
        for (int ch = 0; ch < 2; ch++) begin
            psg_write(4'(3 * ch), 8'(take_bits(6)));
            psg_write(4'(3 * ch + 1), 8'h00);
            psg_write(4'(3 * ch + 2), 8'(take_bits(4)) | 8'h01);
        end
        repeat (400) idle_cycle();

        // Frame interrupt and acknowledge
        io_op(8'hE0, 8'h00, 8'h00, 1'b1, 1'b0);
        waited = 0;
        while (!cpu_interrupt && waited < FRAME_TICKS + 8) begin
            idle_cycle();
            waited++;
        end
        if (!cpu_interrupt) begin
            errors++;
            $display("cpu_interrupt never rose within %0d cycles", FRAME_TICKS + 8);
        end
        bus_step(make_bus(16'h00E0, 8'h00, 1'b1, 1'b0));
        compare_data(data, {1'b1, 7'h7F}, "timer status with interrupt pending");
        idle_cycle();
        compare_irq(cpu_interrupt, 1'b0);

        // Move the PPI, then switch the timer off
        set_map(DEV_PPI, {1'b1, 8'h90, 8'hFC});
        read_check(8'hA9, 8'hFF, "old PPI slot port");
        wd = 8'(take_bits(8));
        io_op(8'h91, 8'h00, wd, 1'b0, 1'b1);
        read_check(8'h91, wd, "moved PPI slot port");
        set_map(DEV_TIMER, {1'b0, 8'hE0, 8'hFE});
        read_check(8'hE0, 8'hFF, "disabled timer status");
        idle_cycle();

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_count);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: sim.f
rtl/msx_bus_pkg.sv
rtl/msx_dev_pkg.sv
rtl/dev_io_map.sv
rtl/dev_latch_port.sv
rtl/dev_psg_tone.sv
rtl/dev_frame_timer.sv
rtl/dev_ppi.sv
rtl/msx_devices.sv
tests/tb_clock.sv
tests/tb_msx_devices.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing -f sim.f --top-module tb_msx_devices; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_msx_devices > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1
